/* decode_patterns.mem */
// pc  instruction  flags  immediate
// flags msb first: writes_rf mem load uload store byte hex branch jump rf1 rf2 auipc illegal
00000100 00b50533 100c 00000000 // add x10, x10, x11
00000104 407302b3 100c 00000000 // sub x5, x6, x7
00000108 023100b3 100c 00000000 // mul x1, x2, x3
0000010c 02a4d433 100c 00000000 // divu x8, x9, x10
00000110 fff00093 1008 ffffffff // addi x1, x0, -1
00000114 7ff10113 1008 000007ff // addi x2, x2, 2047
00000118 40525193 1008 00000405 // srai x3, x4, 5
0000011c 01f31313 1008 0000001f // slli x6, x6, 31
00000120 ffc50283 1c88 fffffffc // lb x5, -4(x10)
00000124 00354283 1e88 00000003 // lbu x5, 3(x10)
00000128 01011303 1c48 00000010 // lh x6, 16(x2)
0000012c ffe15383 1e48 fffffffe // lhu x7, -2(x2)
00000130 0001a403 1c08 00000000 // lw x8, 0(x3)
00000134 005503a3 098c 00000007 // sb x5, 7(x10)
00000138 fe611c23 094c fffffff8 // sh x6, -8(x2)
0000013c 7e70ae23 090c 000007fc // sw x7, 2044(x1)
00000140 00208463 002c 00000008 // beq x1, x2, +8
00000144 fe4198e3 002c fffffff0 // bne x3, x4, -16
00000148 0062f0e3 002c 00000800 // bgeu x5, x6, +2048
0000014c ffdff0ef 1010 fffffffc // jal x1, -4
00000150 0010106f 1010 00001800 // jal x0, +0x1800
00000154 00008067 1018 00000000 // jalr x0, 0(x1)
00000158 123452b7 1000 12345000 // lui x5, 0x12345
0000015c fffff197 1002 fffff000 // auipc x3, 0xfffff
00000160 1005a52f 1c08 00000000 // lr.w x10, (x11)
00000164 00000000 0001 00000000 // all zero
00000168 ffffffff 0001 00000000 // all ones
0000016c 20b50533 0001 00000000 // register op with bad funct7
00000170 0001b403 0001 00000000 // load with funct3 011
00000174 0020a463 0001 00000008 // branch with funct3 010
00000178 41f31313 0001 0000041f // slli with funct7 0100000
0000017c 1015a52f 0001 00000000 // lr.w with rs2 not zero

/* verilog.f */
rv32_pkg.sv
pipe_reg.sv
cl_decode.sv
imm_gen.sv
decode_stage.sv
decode_stage_assert.sv
tb_decode_stage.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= verilog.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j $(JOBS)
PASS_MSG  ?= Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the sim output goes to the console and the pass line decides the status
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* tb_decode_stage.sv */
`default_nettype none

module tb_decode_stage;
    timeunit 1ns;
    timeprecision 1ps;
    import rv32_pkg::*;

    localparam int reset_cycles   = 16;
    localparam int num_patterns   = 32;
    // every pattern goes through once with random timing and once as a burst
    localparam int num_items      = 2 * num_patterns;
    localparam int timeout_cycles = num_items * 8 + 40;

    logic            clk;
    logic            rst_i;
    logic            in_valid_i;
    logic            in_ready_o;
    logic [xlen-1:0] in_pc_i;
    logic [xlen-1:0] in_instr_i;
    logic            out_valid_o;
    logic            out_ready_i;
    logic [xlen-1:0] out_pc_o;
    logic [xlen-1:0] out_instr_o;
    decode_s         out_decode_o;
    logic [xlen-1:0] out_imm_o;

    // four words per pattern: pc, instruction, flags, immediate
    logic [31:0] pat [0:4*num_patterns-1];
    // indices of accepted patterns, oldest first
    int          expect_q [$];
    int          n_accepted = 0;
    int          n_checked  = 0;
    int          errors     = 0;
    int          cycle_cnt  = 0;
    logic        burst      = 1'b0;

    decode_stage u_decode_stage (
        .clk_i        (clk),
        .rst_i        (rst_i),
        .in_valid_i   (in_valid_i),
        .in_ready_o   (in_ready_o),
        .in_pc_i      (in_pc_i),
        .in_instr_i   (in_instr_i),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_pc_o     (out_pc_o),
        .out_instr_o  (out_instr_o),
        .out_decode_o (out_decode_o),
        .out_imm_o    (out_imm_o)
    );

    bind decode_stage decode_stage_assert u_decode_stage_assert (
        .clk_i        (clk_i),
        .rst_i        (rst_i),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_pc_o     (out_pc_o),
        .out_instr_o  (out_instr_o),
        .out_decode_o (out_decode_o),
        .out_imm_o    (out_imm_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

    // 128 words, so a 7-bit address
    function automatic logic [31:0] pattern_word(input int idx, input int field);
        return pat[7'(4 * idx + field)];
    endfunction

    task automatic report_mismatch(input string field, input int idx,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("ERROR at %0d ns: pattern %0d %s expected %h got %h",
                 $time, idx, field, exp, act);
        errors++;
    endtask

    // offer one pattern after a gap and hold it until the DUT takes it
    task automatic offer_pattern(input int idx, input int gap);
        int k;
        for (k = 0; k < gap; k++) begin
            @(negedge clk);
            in_valid_i = 1'b0;
        end
        @(negedge clk);
        in_valid_i = 1'b1;
        in_pc_i    = pattern_word(idx, 0);
        in_instr_i = pattern_word(idx, 1);
        @(posedge clk);
        while (!in_ready_o) @(posedge clk);
        expect_q.push_back(idx);
        n_accepted++;
    endtask

    // called on the falling edge before an output transfer
    task automatic check_output();
        int          idx;
        logic [31:0] exp_flags;
        if (expect_q.size() == 0) begin
            $display("output with pc %h at %0d ns has no accepted instruction behind it",
                     out_pc_o, $time);
            errors++;
        end else begin
            idx       = expect_q.pop_front();
            exp_flags = pattern_word(idx, 2);
            if (out_pc_o !== pattern_word(idx, 0))
                report_mismatch("pc", idx, pattern_word(idx, 0), out_pc_o);
            if (out_instr_o !== pattern_word(idx, 1))
                report_mismatch("instr", idx, pattern_word(idx, 1), out_instr_o);
            if (out_decode_o !== exp_flags[12:0])
                report_mismatch("flags", idx, exp_flags, 32'(out_decode_o));
            if (out_imm_o !== pattern_word(idx, 3))
                report_mismatch("imm", idx, pattern_word(idx, 3), out_imm_o);
            n_checked++;
        end
    endtask

    // execute side: random back-pressure and the output monitor
    initial begin
        int last_cycle;
        int n_burst;
        out_ready_i = 1'b0;
        last_cycle  = 0;
        n_burst     = 0;
        repeat (reset_cycles) @(posedge clk);
        forever begin
            @(negedge clk);
            // low about a third of the time outside the burst
            if (burst)
                out_ready_i = 1'b1;
            else
                out_ready_i = ($urandom % 3) != 0;
            if (out_valid_o && n_accepted == 0) begin
                $display("ERROR at %0d ns: out_valid_o high before any input", $time);
                errors++;
            end
            if (out_valid_o && out_ready_i) begin
                if (burst) begin
                    if (n_burst > 0 && cycle_cnt != last_cycle + 1) begin
                        $display("ERROR at %0d ns: burst output %0d is %0d cycles late",
                                 $time, n_burst, cycle_cnt - last_cycle);
                        errors++;
                    end
                    last_cycle = cycle_cnt;
                    n_burst++;
                end
                check_output();
            end
        end
    end

    // fetch side
    initial begin
        int i;
        void'($urandom(32'h88fcebab));
        rst_i      = 1'b1;
        in_valid_i = 1'b0;
        in_pc_i    = '0;
        in_instr_i = '0;
        $readmemh("decode_patterns.mem", pat);
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        rst_i = 1'b0;
        for (i = 0; i < num_patterns; i++) begin
            offer_pattern(i, $urandom % 4);
        end
        @(negedge clk);
        in_valid_i = 1'b0;
        // drain, then stream everything again with no gaps or stalls
        wait (n_checked == num_patterns);
        @(posedge clk);
        burst = 1'b1;
        for (i = 0; i < num_patterns; i++) begin
            offer_pattern(i, 0);
        end
        @(negedge clk);
        in_valid_i = 1'b0;
        wait (n_checked == num_items);
        // a few idle cycles to catch duplicated outputs
        repeat (5) @(negedge clk);
        $display("checked %0d of %0d outputs, %0d errors", n_checked, num_items, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (reset_cycles + timeout_cycles) @(posedge clk);
        errors++;
        $display("timeout after %0d cycles, %0d of %0d outputs seen, %0d errors",
                 timeout_cycles, n_checked, num_items, errors);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

/* decode_stage_assert.sv */
`default_nettype none

module decode_stage_assert (
    input logic                      clk_i,
    input logic                      rst_i,
    input logic                      out_valid_o,
    input logic                      out_ready_i,
    input logic [rv32_pkg::xlen-1:0] out_pc_o,
    input logic [rv32_pkg::xlen-1:0] out_instr_o,
    input rv32_pkg::decode_s         out_decode_o,
    input logic [rv32_pkg::xlen-1:0] out_imm_o
);
    timeunit 1ns;
    timeprecision 1ps;

    // a stalled output keeps valid and all of its payload
    out_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_pc_o)
            && $stable(out_instr_o) && $stable(out_decode_o) && $stable(out_imm_o))
        else $error("output changed while stalled");

    // output channel comes out of reset empty
    out_reset: assert property (@(posedge clk_i) rst_i |=> !out_valid_o)
        else $error("out_valid_o high right after reset");

endmodule

`default_nettype wire

/* decode_stage.sv */
`default_nettype none

module decode_stage (
    input  logic                        clk_i,
    input  logic                        rst_i,
    // fetch side
    input  logic                        in_valid_i,
    output logic                        in_ready_o,
    input  logic [rv32_pkg::xlen-1:0]   in_pc_i,
    input  logic [rv32_pkg::xlen-1:0]   in_instr_i,
    // execute side
    output logic                        out_valid_o,
    input  logic                        out_ready_i,
    output logic [rv32_pkg::xlen-1:0]   out_pc_o,
    output logic [rv32_pkg::xlen-1:0]   out_instr_o,
    output rv32_pkg::decode_s           out_decode_o,
    output logic [rv32_pkg::xlen-1:0]   out_imm_o
);
    import rv32_pkg::*;

    fetch_s          fetch_in;
    fetch_s          fetch_q;
    logic            fetch_valid;
    logic            fetch_ready;
    decode_s         dec;
    logic [xlen-1:0] imm;
    decoded_s        decoded_in;
    decoded_s        decoded_q;

    assign fetch_in.pc    = in_pc_i;
    assign fetch_in.instr = in_instr_i;

    // input register, first cycle of latency
    pipe_reg #(.payload_t(fetch_s)) u_fetch_reg (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (in_valid_i),
        .ready_o (in_ready_o),
        .data_i  (fetch_in),
        .valid_o (fetch_valid),
        .ready_i (fetch_ready),
        .data_o  (fetch_q)
    );

    // decode and immediate work straight off the held instruction
    cl_decode u_cl_decode (
        .instruction_i (fetch_q.instr),
        .decode_o      (dec)
    );

    imm_gen u_imm_gen (
        .instruction_i (fetch_q.instr),
        .imm_o         (imm)
    );

    assign decoded_in.pc     = fetch_q.pc;
    assign decoded_in.instr  = fetch_q.instr;
    assign decoded_in.decode = dec;
    assign decoded_in.imm    = imm;

    // output register holds the result until execute takes it
    pipe_reg #(.payload_t(decoded_s)) u_decoded_reg (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .valid_i (fetch_valid),
        .ready_o (fetch_ready),
        .data_i  (decoded_in),
        .valid_o (out_valid_o),
        .ready_i (out_ready_i),
        .data_o  (decoded_q)
    );

    assign out_pc_o     = decoded_q.pc;
    assign out_instr_o  = decoded_q.instr;
    assign out_decode_o = decoded_q.decode;
    assign out_imm_o    = decoded_q.imm;

endmodule

`default_nettype wire

/* imm_gen.sv */
`default_nettype none

module imm_gen (
    input  rv32_pkg::instruction_s       instruction_i,
    output logic [rv32_pkg::xlen-1:0]    imm_o
);
    import rv32_pkg::*;

    // flat view of the instruction for bit slicing
    logic [xlen-1:0] ins;
    // sign bit is always bit 31
    logic            sgn;

    assign ins = instruction_i;
    assign sgn = ins[31];

    always_comb begin
        unique case (instruction_i.opcode)
            // i format, shamt sits in the low five bits for shifts
            op_load, op_jalr, op_imm:
                imm_o = {{20{sgn}}, ins[31:20]};
            // s format, split across funct7 and rd
            op_store:
                imm_o = {{20{sgn}}, ins[31:25], ins[11:7]};
            // b format, halfword offset so bit 0 is zero
            op_branch:
                imm_o = {{19{sgn}}, sgn, ins[7], ins[30:25], ins[11:8], 1'b0};
            // u format, upper 20 bits with zero below
            op_lui, op_auipc:
                imm_o = {ins[31:12], 12'b0};
            // j format, also halfword aligned
            op_jal:
                imm_o = {{11{sgn}}, sgn, ins[19:12], ins[20], ins[30:21], 1'b0};
            // register ops and unknown opcodes carry no immediate
            default:
                imm_o = '0;
        endcase
    end

endmodule

`default_nettype wire

/* cl_decode.sv */
`default_nettype none

module cl_decode (
    input  rv32_pkg::instruction_s instruction_i,
    output rv32_pkg::decode_s      decode_o
);
    import rv32_pkg::*;

    // raw flags before the illegal mask
    decode_s flags;

    // writes rd
    always_comb begin
        unique casez (instruction_i)
            rv32_lui, rv32_auipc, rv32_jal, rv32_jalr,
            rv32_lb, rv32_lh, rv32_lw, rv32_lbu, rv32_lhu,
            rv32_addi, rv32_slti, rv32_sltiu, rv32_xori, rv32_ori,
            rv32_andi, rv32_slli, rv32_srli, rv32_srai,
            rv32_add, rv32_sub, rv32_sll, rv32_slt, rv32_sltu,
            rv32_xor, rv32_srl, rv32_sra, rv32_or, rv32_and,
            rv32_mul, rv32_mulh, rv32_mulhsu, rv32_mulhu,
            rv32_div, rv32_divu, rv32_rem, rv32_remu, rv32_lr_w:
                flags.op_writes_rf = 1'b1;
            default:
                flags.op_writes_rf = 1'b0;
        endcase
    end

    // any data memory access, lr.w included
    always_comb begin
        unique casez (instruction_i)
            rv32_lb, rv32_lh, rv32_lw, rv32_lbu, rv32_lhu,
            rv32_sb, rv32_sh, rv32_sw, rv32_lr_w:
                flags.is_mem_op = 1'b1;
            default:
                flags.is_mem_op = 1'b0;
        endcase
    end

    // memory reads
    always_comb begin
        unique casez (instruction_i)
            rv32_lb, rv32_lh, rv32_lw, rv32_lbu, rv32_lhu, rv32_lr_w:
                flags.is_load_op = 1'b1;
            default:
                flags.is_load_op = 1'b0;
        endcase
    end

    // zero-extending loads
    always_comb begin
        unique casez (instruction_i)
            rv32_lbu, rv32_lhu:
                flags.is_uload_op = 1'b1;
            default:
                flags.is_uload_op = 1'b0;
        endcase
    end

    // memory writes
    always_comb begin
        unique casez (instruction_i)
            rv32_sb, rv32_sh, rv32_sw:
                flags.is_store_op = 1'b1;
            default:
                flags.is_store_op = 1'b0;
        endcase
    end

    // byte width, signed or not
    always_comb begin
        unique casez (instruction_i)
            rv32_lb, rv32_lbu, rv32_sb:
                flags.is_byte_op = 1'b1;
            default:
                flags.is_byte_op = 1'b0;
        endcase
    end

    // halfword width, signed or not
    always_comb begin
        unique casez (instruction_i)
            rv32_lh, rv32_lhu, rv32_sh:
                flags.is_hex_op = 1'b1;
            default:
                flags.is_hex_op = 1'b0;
        endcase
    end

    // conditional branches
    always_comb begin
        unique casez (instruction_i)
            rv32_beq, rv32_bne, rv32_blt, rv32_bge, rv32_bltu, rv32_bgeu:
                flags.is_branch_op = 1'b1;
            default:
                flags.is_branch_op = 1'b0;
        endcase
    end

    // unconditional jumps
    always_comb begin
        unique casez (instruction_i)
            rv32_jal, rv32_jalr:
                flags.is_jump_op = 1'b1;
            default:
                flags.is_jump_op = 1'b0;
        endcase
    end

    // rs1 read, lr.w takes its address from rs1
    always_comb begin
        unique casez (instruction_i)
            rv32_jalr, rv32_lr_w,
            rv32_beq, rv32_bne, rv32_blt, rv32_bge, rv32_bltu, rv32_bgeu,
            rv32_lb, rv32_lh, rv32_lw, rv32_lbu, rv32_lhu,
            rv32_sb, rv32_sh, rv32_sw,
            rv32_addi, rv32_slti, rv32_sltiu, rv32_xori, rv32_ori,
            rv32_andi, rv32_slli, rv32_srli, rv32_srai,
            rv32_add, rv32_sub, rv32_sll, rv32_slt, rv32_sltu,
            rv32_xor, rv32_srl, rv32_sra, rv32_or, rv32_and,
            rv32_mul, rv32_mulh, rv32_mulhsu, rv32_mulhu,
            rv32_div, rv32_divu, rv32_rem, rv32_remu:
                flags.op_reads_rf1 = 1'b1;
            default:
                flags.op_reads_rf1 = 1'b0;
        endcase
    end

    // rs2 read: branches, stores and register ops
    always_comb begin
        unique casez (instruction_i)
            rv32_beq, rv32_bne, rv32_blt, rv32_bge, rv32_bltu, rv32_bgeu,
            rv32_sb, rv32_sh, rv32_sw,
            rv32_add, rv32_sub, rv32_sll, rv32_slt, rv32_sltu,
            rv32_xor, rv32_srl, rv32_sra, rv32_or, rv32_and,
            rv32_mul, rv32_mulh, rv32_mulhsu, rv32_mulhu,
            rv32_div, rv32_divu, rv32_rem, rv32_remu:
                flags.op_reads_rf2 = 1'b1;
            default:
                flags.op_reads_rf2 = 1'b0;
        endcase
    end

    // auipc only needs the opcode field
    always_comb begin
        unique case (instruction_i.opcode)
            op_auipc:
                flags.op_is_auipc = 1'b1;
            default:
                flags.op_is_auipc = 1'b0;
        endcase
    end

    // every known instruction writes rd, stores or branches,
    // so anything else is illegal
    assign flags.is_illegal = ~(flags.op_writes_rf | flags.is_store_op | flags.is_branch_op);

    // an illegal instruction reports nothing but is_illegal
    always_comb begin
        decode_o = flags;
        if (flags.is_illegal) begin
            decode_o = '0;
            decode_o.is_illegal = 1'b1;
        end
    end

endmodule

`default_nettype wire

/* pipe_reg.sv */
`default_nettype none

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk_i,
    input  logic     rst_i,
    // upstream side
    input  logic     valid_i,
    output logic     ready_o,
    input  payload_t data_i,
    // downstream side
    output logic     valid_o,
    input  logic     ready_i,
    output payload_t data_o
);

    logic     full_r;
    payload_t data_r;

    // accept when empty or when the held item leaves this cycle
    assign ready_o = ~full_r | ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            full_r <= 1'b0;
        end else if (valid_i & ready_o) begin
            full_r <= 1'b1;
        end else if (ready_i) begin
            // item taken with nothing new behind it
            full_r <= 1'b0;
        end
    end

    // payload loads on every transfer in
    always_ff @(posedge clk_i) begin
        if (valid_i & ready_o) begin
            data_r <= data_i;
        end
    end

    assign valid_o = full_r;
    assign data_o  = data_r;

endmodule

`default_nettype wire

/* rv32_pkg.sv */
`default_nettype none

package rv32_pkg;

    // data and address width
    localparam int xlen = 32;

    // major opcodes, bits [6:0] of the instruction
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_amo    = 7'b0101111;

    // funct7 groups of the register and shift ops
    localparam logic [6:0] f7_base   = 7'b0000000;
    localparam logic [6:0] f7_alt    = 7'b0100000;
    localparam logic [6:0] f7_muldiv = 7'b0000001;
    // funct5 of lr.w, aq and rl bits follow it
    localparam logic [4:0] f5_lr_w   = 5'b00010;

    // funct3 memory widths
    localparam logic [2:0] f3_byte   = 3'b000;
    localparam logic [2:0] f3_half   = 3'b001;
    localparam logic [2:0] f3_word   = 3'b010;
    localparam logic [2:0] f3_ubyte  = 3'b100;
    localparam logic [2:0] f3_uhalf  = 3'b101;

    // full instruction match patterns, ? bits are don't care in casez
    localparam logic [xlen-1:0] rv32_lui    = {25'b?, op_lui};
    localparam logic [xlen-1:0] rv32_auipc  = {25'b?, op_auipc};
    localparam logic [xlen-1:0] rv32_jal    = {25'b?, op_jal};
    localparam logic [xlen-1:0] rv32_jalr   = {17'b?, 3'b000, 5'b?, op_jalr};
    // conditional branches
    localparam logic [xlen-1:0] rv32_beq    = {17'b?, 3'b000, 5'b?, op_branch};
    localparam logic [xlen-1:0] rv32_bne    = {17'b?, 3'b001, 5'b?, op_branch};
    localparam logic [xlen-1:0] rv32_blt    = {17'b?, 3'b100, 5'b?, op_branch};
    localparam logic [xlen-1:0] rv32_bge    = {17'b?, 3'b101, 5'b?, op_branch};
    localparam logic [xlen-1:0] rv32_bltu   = {17'b?, 3'b110, 5'b?, op_branch};
    localparam logic [xlen-1:0] rv32_bgeu   = {17'b?, 3'b111, 5'b?, op_branch};
    // loads and stores
    localparam logic [xlen-1:0] rv32_lb     = {17'b?, f3_byte, 5'b?, op_load};
    localparam logic [xlen-1:0] rv32_lh     = {17'b?, f3_half, 5'b?, op_load};
    localparam logic [xlen-1:0] rv32_lw     = {17'b?, f3_word, 5'b?, op_load};
    localparam logic [xlen-1:0] rv32_lbu    = {17'b?, f3_ubyte, 5'b?, op_load};
    localparam logic [xlen-1:0] rv32_lhu    = {17'b?, f3_uhalf, 5'b?, op_load};
    localparam logic [xlen-1:0] rv32_sb     = {17'b?, f3_byte, 5'b?, op_store};
    localparam logic [xlen-1:0] rv32_sh     = {17'b?, f3_half, 5'b?, op_store};
    localparam logic [xlen-1:0] rv32_sw     = {17'b?, f3_word, 5'b?, op_store};
    // register-immediate ops, shifts carry funct7 above the shamt
    localparam logic [xlen-1:0] rv32_addi   = {17'b?, 3'b000, 5'b?, op_imm};
    localparam logic [xlen-1:0] rv32_slti   = {17'b?, 3'b010, 5'b?, op_imm};
    localparam logic [xlen-1:0] rv32_sltiu  = {17'b?, 3'b011, 5'b?, op_imm};
    localparam logic [xlen-1:0] rv32_xori   = {17'b?, 3'b100, 5'b?, op_imm};
    localparam logic [xlen-1:0] rv32_ori    = {17'b?, 3'b110, 5'b?, op_imm};
    localparam logic [xlen-1:0] rv32_andi   = {17'b?, 3'b111, 5'b?, op_imm};
    localparam logic [xlen-1:0] rv32_slli   = {f7_base, 10'b?, 3'b001, 5'b?, op_imm};
    localparam logic [xlen-1:0] rv32_srli   = {f7_base, 10'b?, 3'b101, 5'b?, op_imm};
    localparam logic [xlen-1:0] rv32_srai   = {f7_alt, 10'b?, 3'b101, 5'b?, op_imm};
    // register-register ops
    localparam logic [xlen-1:0] rv32_add    = {f7_base, 10'b?, 3'b000, 5'b?, op_reg};
    localparam logic [xlen-1:0] rv32_sub    = {f7_alt, 10'b?, 3'b000, 5'b?, op_reg};
    localparam logic [xlen-1:0] rv32_sll    = {f7_base, 10'b?, 3'b001, 5'b?, op_reg};
    localparam logic [xlen-1:0] rv32_slt    = {f7_base, 10'b?, 3'b010, 5'b?, op_reg};
    localparam logic [xlen-1:0] rv32_sltu   = {f7_base, 10'b?, 3'b011, 5'b?, op_reg};
    localparam logic [xlen-1:0] rv32_xor    = {f7_base, 10'b?, 3'b100, 5'b?, op_reg};
    localparam logic [xlen-1:0] rv32_srl    = {f7_base, 10'b?, 3'b101, 5'b?, op_reg};
    localparam logic [xlen-1:0] rv32_sra    = {f7_alt, 10'b?, 3'b101, 5'b?, op_reg};
    localparam logic [xlen-1:0] rv32_or     = {f7_base, 10'b?, 3'b110, 5'b?, op_reg};
    localparam logic [xlen-1:0] rv32_and    = {f7_base, 10'b?, 3'b111, 5'b?, op_reg};
    // m extension
    localparam logic [xlen-1:0] rv32_mul    = {f7_muldiv, 10'b?, 3'b000, 5'b?, op_reg};
    localparam logic [xlen-1:0] rv32_mulh   = {f7_muldiv, 10'b?, 3'b001, 5'b?, op_reg};
    localparam logic [xlen-1:0] rv32_mulhsu = {f7_muldiv, 10'b?, 3'b010, 5'b?, op_reg};
    localparam logic [xlen-1:0] rv32_mulhu  = {f7_muldiv, 10'b?, 3'b011, 5'b?, op_reg};
    localparam logic [xlen-1:0] rv32_div    = {f7_muldiv, 10'b?, 3'b100, 5'b?, op_reg};
    localparam logic [xlen-1:0] rv32_divu   = {f7_muldiv, 10'b?, 3'b101, 5'b?, op_reg};
    localparam logic [xlen-1:0] rv32_rem    = {f7_muldiv, 10'b?, 3'b110, 5'b?, op_reg};
    localparam logic [xlen-1:0] rv32_remu   = {f7_muldiv, 10'b?, 3'b111, 5'b?, op_reg};
    // load reserved, rs2 must be zero
    localparam logic [xlen-1:0] rv32_lr_w   = {f5_lr_w, 2'b?, 5'b00000, 5'b?, f3_word, 5'b?, op_amo};

    // instruction fields, msb first
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instruction_s;

    // control flags produced by the decoder
    typedef struct packed {
        logic op_writes_rf;
        logic is_mem_op;
        logic is_load_op;
        logic is_uload_op;
        logic is_store_op;
        logic is_byte_op;
        logic is_hex_op;
        logic is_branch_op;
        logic is_jump_op;
        logic op_reads_rf1;
        logic op_reads_rf2;
        logic op_is_auipc;
        logic is_illegal;
    } decode_s;

    // payload of the input register
    typedef struct packed {
        logic [xlen-1:0] pc;
        instruction_s    instr;
    } fetch_s;

    // payload of the output register
    typedef struct packed {
        logic [xlen-1:0] pc;
        instruction_s    instr;
        decode_s         decode;
        logic [xlen-1:0] imm;
    } decoded_s;

endpackage

`default_nettype wire
